/* hdl/hsid_x_pkg.sv */
package hsid_x_pkg;

  localparam int WORD_WIDTH       = 32;   // Bus, memory and result word
  localparam int HSI_BANDS        = 254;  // Max bands per pixel
  localparam int HSI_LIBRARY_SIZE = 4095; // Max library entries
  localparam int SAMPLE_WIDTH     = 12;   // Low bits of a memory word used as sample
  localparam int REG_ADDR_WIDTH   = 8;
  localparam int BAND_CNT_WIDTH   = $clog2(HSI_BANDS);        // 8
  localparam int LIB_IDX_WIDTH    = $clog2(HSI_LIBRARY_SIZE); // 12

  typedef logic [WORD_WIDTH-1:0]     word_t;
  typedef logic [SAMPLE_WIDTH-1:0]   sample_t;
  typedef logic [BAND_CNT_WIDTH-1:0] band_cnt_t;
  typedef logic [LIB_IDX_WIDTH-1:0]  lib_idx_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  // Register byte offsets
  localparam reg_addr_t REG_STATUS        = 8'h00;
  localparam reg_addr_t REG_LIBRARY_SIZE  = 8'h04;
  localparam reg_addr_t REG_PIXEL_BANDS   = 8'h08;
  localparam reg_addr_t REG_CAPTURED_ADDR = 8'h0C;
  localparam reg_addr_t REG_LIBRARY_ADDR  = 8'h10;
  localparam reg_addr_t REG_MSE_MIN_REF   = 8'h14;
  localparam reg_addr_t REG_MSE_MIN_VALUE = 8'h18;
  localparam reg_addr_t REG_MSE_MAX_REF   = 8'h1C;
  localparam reg_addr_t REG_MSE_MAX_VALUE = 8'h20;

  // Status register bit positions
  localparam int STATUS_START = 0; // W1, self-clearing
  localparam int STATUS_CLEAR = 1; // W1, self-clearing
  localparam int STATUS_IDLE  = 2;
  localparam int STATUS_READY = 3;
  localparam int STATUS_DONE  = 4;
  localparam int STATUS_ERROR = 5;

  typedef enum logic [2:0] {
    S_IDLE,
    S_READ_CAP, // Fetch captured sample of current band
    S_READ_LIB, // Fetch library sample of current band
    S_NEXT,     // Step to next library entry
    S_DONE,
    S_ERROR
  } seq_state_t;

endpackage

/* hdl/hsid_x_ctrl_reg.sv */
module hsid_x_ctrl_reg (
  input  logic                  clk,
  input  logic                  rst_n,
  // Register bus
  input  logic                  reg_valid,
  input  logic                  reg_write,
  input  hsid_x_pkg::reg_addr_t reg_addr,  // Byte offset
  input  hsid_x_pkg::word_t     reg_wdata,
  output hsid_x_pkg::word_t     reg_rdata,
  output logic                  reg_error,
  output logic                  reg_ready,
  // Engine handshake
  output logic                  start,     // One-cycle pulse
  output logic                  clear,     // One-cycle pulse
  input  logic                  idle,
  input  logic                  ready,
  input  logic                  done,
  input  logic                  error,
  // Configuration levels
  output hsid_x_pkg::lib_idx_t  library_size,
  output hsid_x_pkg::band_cnt_t pixel_bands,
  output hsid_x_pkg::word_t     captured_pixel_addr,
  output hsid_x_pkg::word_t     library_pixel_addr,
  // Results
  input  hsid_x_pkg::lib_idx_t  mse_min_ref,
  input  hsid_x_pkg::word_t     mse_min_value,
  input  hsid_x_pkg::lib_idx_t  mse_max_ref,
  input  hsid_x_pkg::word_t     mse_max_value
);

  logic busy;       // Engine owns the config, incl. the cycle of the start pulse
  logic wr_en;
  logic addr_known; // Offset decodes to a register
  logic cfg_addr;   // Offset is one of the four config registers
  logic status_wr;
  logic start_req;
  logic wr_locked;  // Write that must be dropped

  assign busy  = ~idle | start; // A second start right after the first is refused
  assign wr_en = reg_valid & reg_write;

  always_comb begin
    addr_known = 1'b1;
    cfg_addr   = 1'b0;
    reg_rdata  = '0;
    case (reg_addr)
      hsid_x_pkg::REG_STATUS: begin
        reg_rdata[hsid_x_pkg::STATUS_IDLE]  = idle;
        reg_rdata[hsid_x_pkg::STATUS_READY] = ready;
        reg_rdata[hsid_x_pkg::STATUS_DONE]  = done;
        reg_rdata[hsid_x_pkg::STATUS_ERROR] = error; // Start and clear read back as 0
      end
      hsid_x_pkg::REG_LIBRARY_SIZE: begin
        cfg_addr  = 1'b1;
        reg_rdata = hsid_x_pkg::word_t'(library_size);
      end
      hsid_x_pkg::REG_PIXEL_BANDS: begin
        cfg_addr  = 1'b1;
        reg_rdata = hsid_x_pkg::word_t'(pixel_bands);
      end
      hsid_x_pkg::REG_CAPTURED_ADDR: begin
        cfg_addr  = 1'b1;
        reg_rdata = captured_pixel_addr;
      end
      hsid_x_pkg::REG_LIBRARY_ADDR: begin
        cfg_addr  = 1'b1;
        reg_rdata = library_pixel_addr;
      end
      hsid_x_pkg::REG_MSE_MIN_REF:   reg_rdata = hsid_x_pkg::word_t'(mse_min_ref); // Zero-extend
      hsid_x_pkg::REG_MSE_MIN_VALUE: reg_rdata = mse_min_value;
      hsid_x_pkg::REG_MSE_MAX_REF:   reg_rdata = hsid_x_pkg::word_t'(mse_max_ref); // Zero-extend
      hsid_x_pkg::REG_MSE_MAX_VALUE: reg_rdata = mse_max_value;
      default:                       addr_known = 1'b0;
    endcase
  end

  assign status_wr = wr_en & (reg_addr == hsid_x_pkg::REG_STATUS);
  assign start_req = status_wr & reg_wdata[hsid_x_pkg::STATUS_START];
  assign wr_locked = wr_en & busy & (cfg_addr | start_req); // Clear bit never locked

  assign reg_ready = reg_valid; // Single-cycle access
  assign reg_error = reg_valid & (~addr_known | wr_locked);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start               <= 1'b0;
      clear               <= 1'b0;
      library_size        <= '0;
      pixel_bands         <= '0;
      captured_pixel_addr <= '0;
      library_pixel_addr  <= '0;
    end else begin
      start <= start_req & ~busy;                                // Hardware clears next cycle
      clear <= status_wr & reg_wdata[hsid_x_pkg::STATUS_CLEAR]; // Always accepted
      if (wr_en && cfg_addr && !busy) begin
        case (reg_addr)
          hsid_x_pkg::REG_LIBRARY_SIZE:
            library_size <= reg_wdata[hsid_x_pkg::LIB_IDX_WIDTH-1:0];
          hsid_x_pkg::REG_PIXEL_BANDS:
            pixel_bands <= reg_wdata[hsid_x_pkg::BAND_CNT_WIDTH-1:0];
          hsid_x_pkg::REG_CAPTURED_ADDR: captured_pixel_addr <= reg_wdata;
          default:                       library_pixel_addr  <= reg_wdata; // REG_LIBRARY_ADDR
        endcase
      end
    end
  end

endmodule

/* hdl/hsid_x_sequencer.sv */
module hsid_x_sequencer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic                  clear,
  input  hsid_x_pkg::lib_idx_t  library_size,
  input  hsid_x_pkg::band_cnt_t pixel_bands,
  input  hsid_x_pkg::word_t     captured_pixel_addr,
  input  hsid_x_pkg::word_t     library_pixel_addr,
  output logic                  mem_req,
  output hsid_x_pkg::word_t     mem_addr,    // Word address
  output logic                  cap_valid,   // mem_rdata holds captured sample
  output logic                  lib_valid,   // mem_rdata holds library sample
  output logic                  entry_last,  // Library sample of last band
  output hsid_x_pkg::lib_idx_t  entry_idx,
  output logic                  first_entry, // Next sum belongs to entry 0
  output logic                  idle,
  output logic                  ready,
  output logic                  done,
  output logic                  error
);

  hsid_x_pkg::seq_state_t state;
  hsid_x_pkg::band_cnt_t  band_idx;
  hsid_x_pkg::word_t      cap_ptr;   // Captured sample address of current band
  hsid_x_pkg::word_t      lib_ptr;   // Running library address, never reset between entries
  logic                   last_band;
  logic                   last_entry;
  logic                   zero_cfg;
  logic                   sum_stage; // Accumulator emits its sum this cycle

  assign last_band  = (band_idx == hsid_x_pkg::band_cnt_t'(pixel_bands - 1'b1));
  assign last_entry = (entry_idx == hsid_x_pkg::lib_idx_t'(library_size - 1'b1));
  assign zero_cfg   = (library_size == '0) | (pixel_bands == '0);

  assign idle     = (state == hsid_x_pkg::S_IDLE);
  assign ready    = idle & ~zero_cfg;
  assign mem_req  = (state == hsid_x_pkg::S_READ_CAP) | (state == hsid_x_pkg::S_READ_LIB);
  assign mem_addr = (state == hsid_x_pkg::S_READ_LIB) ? lib_ptr : cap_ptr;

  // Strobes delayed one cycle to meet mem_rdata
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cap_valid  <= 1'b0;
      lib_valid  <= 1'b0;
      entry_last <= 1'b0;
      sum_stage  <= 1'b0;
    end else begin
      cap_valid  <= (state == hsid_x_pkg::S_READ_CAP);
      lib_valid  <= (state == hsid_x_pkg::S_READ_LIB);
      entry_last <= (state == hsid_x_pkg::S_READ_LIB) & last_band;
      sum_stage  <= entry_last; // Same cycle as sum_valid
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= hsid_x_pkg::S_IDLE;
      band_idx    <= '0;
      entry_idx   <= '0;
      cap_ptr     <= '0;
      lib_ptr     <= '0;
      first_entry <= 1'b0;
      done        <= 1'b0;
      error       <= 1'b0;
    end else begin
      if (clear) begin
        done  <= 1'b0;
        error <= 1'b0;
      end
      if (sum_stage) first_entry <= 1'b0; // Entry 0 result consumed
      case (state)
        hsid_x_pkg::S_IDLE: if (start) begin
          done        <= 1'b0;
          error       <= 1'b0;
          band_idx    <= '0;
          entry_idx   <= '0;
          cap_ptr     <= captured_pixel_addr;
          lib_ptr     <= library_pixel_addr;
          first_entry <= 1'b1;
          state       <= zero_cfg ? hsid_x_pkg::S_ERROR : hsid_x_pkg::S_READ_CAP;
        end
        hsid_x_pkg::S_READ_CAP: state <= hsid_x_pkg::S_READ_LIB;
        hsid_x_pkg::S_READ_LIB: begin
          lib_ptr <= lib_ptr + 1'b1; // Walks k*bands + b without a multiply
          cap_ptr <= cap_ptr + 1'b1;
          if (last_band) begin
            band_idx <= '0;
            state    <= hsid_x_pkg::S_NEXT;
          end else begin
            band_idx <= band_idx + 1'b1;
            state    <= hsid_x_pkg::S_READ_CAP;
          end
        end
        hsid_x_pkg::S_NEXT: begin
          cap_ptr <= captured_pixel_addr; // Rewind captured pixel
          if (last_entry) begin
            state <= hsid_x_pkg::S_DONE;   // Last sum reaches min/max this cycle
          end else begin
            entry_idx <= entry_idx + 1'b1;
            state     <= hsid_x_pkg::S_READ_CAP;
          end
        end
        hsid_x_pkg::S_DONE: begin
          done  <= 1'b1; // Results settle on this edge
          state <= hsid_x_pkg::S_IDLE;
        end
        default: begin  // S_ERROR
          error <= 1'b1;
          state <= hsid_x_pkg::S_IDLE;
        end
      endcase
    end
  end

endmodule

/* hdl/hsid_x_mse_accum.sv */
module hsid_x_mse_accum (
  input  logic                 clk,
  input  logic                 rst_n,
  input  hsid_x_pkg::word_t    mem_rdata,
  input  logic                 cap_valid,
  input  logic                 lib_valid,
  input  logic                 entry_last,
  input  hsid_x_pkg::lib_idx_t entry_idx,
  output logic                 sum_valid,  // One-cycle pulse per entry
  output hsid_x_pkg::word_t    sum_value,  // Unnormalised sum of squared errors
  output hsid_x_pkg::lib_idx_t sum_ref
);

  hsid_x_pkg::sample_t                   sample;     // Low bits of memory word
  hsid_x_pkg::sample_t                   cap_sample; // Captured sample of current band
  hsid_x_pkg::sample_t                   diff;
  logic [2*hsid_x_pkg::SAMPLE_WIDTH-1:0] diff_sq;
  hsid_x_pkg::word_t                     acc;
  hsid_x_pkg::word_t                     acc_next;

  assign sample = mem_rdata[hsid_x_pkg::SAMPLE_WIDTH-1:0];

  // Absolute difference keeps the square unsigned and narrow
  assign diff     = (sample > cap_sample) ? sample - cap_sample : cap_sample - sample;
  assign diff_sq  = diff * diff;
  assign acc_next = acc + hsid_x_pkg::word_t'(diff_sq);

  always_ff @(posedge clk) begin
    if (cap_valid) cap_sample <= sample;
    if (lib_valid && entry_last) begin
      sum_value <= acc_next;
      sum_ref   <= entry_idx; // Entry counter has not yet advanced
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc       <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= lib_valid & entry_last;
      if (lib_valid) acc <= entry_last ? '0 : acc_next; // Restart for next entry
    end
  end

endmodule

/* hdl/hsid_x_min_max.sv */
module hsid_x_min_max (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sum_valid,
  input  hsid_x_pkg::word_t    sum_value,
  input  hsid_x_pkg::lib_idx_t sum_ref,
  input  logic                 first_entry, // First result of a run
  output hsid_x_pkg::lib_idx_t mse_min_ref,
  output hsid_x_pkg::word_t    mse_min_value,
  output hsid_x_pkg::lib_idx_t mse_max_ref,
  output hsid_x_pkg::word_t    mse_max_value
);

  logic new_min;
  logic new_max;

  // Strict compares keep the earliest entry on a tie
  assign new_min = sum_valid & (first_entry | (sum_value < mse_min_value));
  assign new_max = sum_valid & (first_entry | (sum_value > mse_max_value));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mse_min_ref   <= '0;
      mse_min_value <= '0;
      mse_max_ref   <= '0;
      mse_max_value <= '0;
    end else begin
      if (new_min) begin
        mse_min_ref   <= sum_ref;
        mse_min_value <= sum_value;
      end
      if (new_max) begin
        mse_max_ref   <= sum_ref;
        mse_max_value <= sum_value;
      end
    end
  end

endmodule

/* hdl/hsid_x_top.sv */
module hsid_x_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // Register bus
  input  logic                  reg_valid,
  input  logic                  reg_write,
  input  hsid_x_pkg::reg_addr_t reg_addr,
  input  hsid_x_pkg::word_t     reg_wdata,
  output hsid_x_pkg::word_t     reg_rdata,
  output logic                  reg_error,
  output logic                  reg_ready,
  // Word memory, data one cycle after request
  output logic                  mem_req,
  output hsid_x_pkg::word_t     mem_addr,
  input  hsid_x_pkg::word_t     mem_rdata
);

  logic                  start;
  logic                  clear;
  logic                  idle;
  logic                  ready;
  logic                  done;
  logic                  error;
  hsid_x_pkg::lib_idx_t  library_size;
  hsid_x_pkg::band_cnt_t pixel_bands;
  hsid_x_pkg::word_t     captured_pixel_addr;
  hsid_x_pkg::word_t     library_pixel_addr;
  logic                  cap_valid;
  logic                  lib_valid;
  logic                  entry_last;
  hsid_x_pkg::lib_idx_t  entry_idx;
  logic                  first_entry;
  logic                  sum_valid;
  hsid_x_pkg::word_t     sum_value;
  hsid_x_pkg::lib_idx_t  sum_ref;
  hsid_x_pkg::lib_idx_t  mse_min_ref;
  hsid_x_pkg::word_t     mse_min_value;
  hsid_x_pkg::lib_idx_t  mse_max_ref;
  hsid_x_pkg::word_t     mse_max_value;

  hsid_x_ctrl_reg i_hsid_x_ctrl_reg (
    .clk, .rst_n,
    .reg_valid, .reg_write, .reg_addr, .reg_wdata,
    .reg_rdata, .reg_error, .reg_ready,
    .start, .clear, .idle, .ready, .done, .error,
    .library_size, .pixel_bands, .captured_pixel_addr, .library_pixel_addr,
    .mse_min_ref, .mse_min_value, .mse_max_ref, .mse_max_value
  );

  hsid_x_sequencer i_hsid_x_sequencer (
    .clk, .rst_n,
    .start, .clear,
    .library_size, .pixel_bands, .captured_pixel_addr, .library_pixel_addr,
    .mem_req, .mem_addr,
    .cap_valid, .lib_valid, .entry_last, .entry_idx, .first_entry,
    .idle, .ready, .done, .error
  );

  hsid_x_mse_accum i_hsid_x_mse_accum (
    .clk, .rst_n,
    .mem_rdata, .cap_valid, .lib_valid, .entry_last, .entry_idx,
    .sum_valid, .sum_value, .sum_ref
  );

  hsid_x_min_max i_hsid_x_min_max (
    .clk, .rst_n,
    .sum_valid, .sum_value, .sum_ref, .first_entry,
    .mse_min_ref, .mse_min_value, .mse_max_ref, .mse_max_value
  );

endmodule

/* bench/hsid_x_properties.sv */
module hsid_x_properties (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic mem_req,
  input logic idle,
  input logic done,
  input logic error
);
  timeunit 1ns;
  timeprecision 100ps;

  // Start comes from a self-clearing register bit and always wakes the engine
  start_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
                                  start |=> !start && !idle)
    else $error("start stayed high or the engine did not leave idle");

  // No memory traffic until a start wakes the engine
  idle_no_req_a: assert property (@(posedge clk) disable iff (!rst_n)
                                  idle && !start |=> !mem_req)
    else $error("memory request issued while idle");

  done_error_a: assert property (@(posedge clk) disable iff (!rst_n) !(done && error))
    else $error("done and error both high");  // A run ends one way only

endmodule

// The sequencer sees every signal checked here
bind hsid_x_sequencer hsid_x_properties i_hsid_x_properties (
  .clk     (clk),
  .rst_n   (rst_n),
  .start   (start),
  .mem_req (mem_req),
  .idle    (idle),
  .done    (done),
  .error   (error)
);

/* bench/hsid_x_tb.sv */
module hsid_x_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD     = 100;
  localparam int SEED           = 28976;
  localparam int MEM_AW         = 10;            // Word memory of 1024 entries
  localparam int MEM_DEPTH      = 1 << MEM_AW;
  localparam int MAX_BANDS      = 16;            // Random runs kept short
  localparam int MAX_LIB        = 12;
  localparam int NUM_RUNS       = 6;             // Random, tie, busy and zero-size runs
  localparam int RUN_CYCLES     = MAX_LIB * (2 * MAX_BANDS + 1) + 8;
  localparam int REG_ACCESSES   = 120;           // Two cycles each
  localparam int TIMEOUT_CYCLES = 2 * (NUM_RUNS * RUN_CYCLES + 2 * REG_ACCESSES);

  // Status register bits
  localparam hsid_x_pkg::word_t START_BIT = 32'h1 << hsid_x_pkg::STATUS_START;
  localparam hsid_x_pkg::word_t CLEAR_BIT = 32'h1 << hsid_x_pkg::STATUS_CLEAR;
  localparam hsid_x_pkg::word_t IDLE_BIT  = 32'h1 << hsid_x_pkg::STATUS_IDLE;
  localparam hsid_x_pkg::word_t READY_BIT = 32'h1 << hsid_x_pkg::STATUS_READY;
  localparam hsid_x_pkg::word_t DONE_BIT  = 32'h1 << hsid_x_pkg::STATUS_DONE;
  localparam hsid_x_pkg::word_t ERROR_BIT = 32'h1 << hsid_x_pkg::STATUS_ERROR;

  logic                  clk;
  logic                  rst_n;
  logic                  reg_valid;
  logic                  reg_write;
  hsid_x_pkg::reg_addr_t reg_addr;
  hsid_x_pkg::word_t     reg_wdata;
  hsid_x_pkg::word_t     reg_rdata;
  logic                  reg_error;
  logic                  reg_ready;
  logic                  mem_req;
  hsid_x_pkg::word_t     mem_addr;
  hsid_x_pkg::word_t     mem_rdata = '0;

  hsid_x_pkg::word_t mem [MEM_DEPTH];
  logic              rd_pending = 1'b0; // Read issued in the previous cycle
  hsid_x_pkg::word_t rd_addr    = '0;

  // Pending checks for the compare process
  string             name_q[$];
  hsid_x_pkg::word_t act_q[$];
  hsid_x_pkg::word_t exp_q[$];
  event              check_ev;
  int                err_count   = 0;
  int                check_count = 0;
  int                cycle_count;

  hsid_x_top i_hsid_x_top (
    .clk, .rst_n,
    .reg_valid, .reg_write, .reg_addr, .reg_wdata,
    .reg_rdata, .reg_error, .reg_ready,
    .mem_req, .mem_addr, .mem_rdata
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Data for a request seen at one falling edge goes out at the next
  always @(negedge clk) begin
    if (rd_pending) mem_rdata <= mem[rd_addr[MEM_AW-1:0]];
    rd_pending <= mem_req;
    rd_addr    <= mem_addr;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: no result after %0d cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // Compare process, drains every queued check
  initial begin
    string             name;
    hsid_x_pkg::word_t act;
    hsid_x_pkg::word_t exp;
    forever begin
      @(check_ev);
      while (name_q.size() > 0) begin
        name = name_q.pop_front();
        act  = act_q.pop_front();
        exp  = exp_q.pop_front();
        check_count++;
        if (act !== exp) begin
          err_count++;
          $display("error: %s got 0x%h expected 0x%h", name, act, exp);
        end
      end
    end
  end

  function automatic hsid_x_pkg::sample_t sample_at(input hsid_x_pkg::word_t addr);
    return mem[addr[MEM_AW-1:0]][hsid_x_pkg::SAMPLE_WIDTH-1:0]; // Upper bits ignored
  endfunction

  // Sum of squared band differences per entry, first occurrence wins a tie
  function automatic void ref_min_max(
    input  hsid_x_pkg::word_t cap_addr,
    input  hsid_x_pkg::word_t lib_addr,
    input  int                bands,
    input  int                lib_size,
    output int                min_ref,
    output hsid_x_pkg::word_t min_val,
    output int                max_ref,
    output hsid_x_pkg::word_t max_val
  );
    hsid_x_pkg::word_t sum;
    int                diff;
    min_ref = 0;
    max_ref = 0;
    min_val = '0;
    max_val = '0;
    for (int k = 0; k < lib_size; k++) begin
      sum = '0;
      for (int b = 0; b < bands; b++) begin
        diff = int'(sample_at(lib_addr + hsid_x_pkg::word_t'(k * bands + b)))
             - int'(sample_at(cap_addr + hsid_x_pkg::word_t'(b)));
        sum  = sum + hsid_x_pkg::word_t'(diff * diff);
      end
      if (k == 0 || sum < min_val) begin
        min_ref = k;
        min_val = sum;
      end
      if (k == 0 || sum > max_val) begin
        max_ref = k;
        max_val = sum;
      end
    end
  endfunction

  task automatic queue_check(input string name, input hsid_x_pkg::word_t act,
                             input hsid_x_pkg::word_t exp);
    name_q.push_back(name);
    act_q.push_back(act);
    exp_q.push_back(exp);
    -> check_ev;
  endtask

  // Single-cycle bus access, response sampled mid-cycle
  task automatic reg_write_task(input hsid_x_pkg::reg_addr_t addr,
                                input hsid_x_pkg::word_t data, output logic err);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_write = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    #(CLK_PERIOD / 4);
    err = reg_error;
    queue_check("reg_ready", hsid_x_pkg::word_t'(reg_ready), 32'h1); // Same-cycle answer
    @(negedge clk);
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  task automatic reg_read_task(input hsid_x_pkg::reg_addr_t addr,
                               output hsid_x_pkg::word_t data, output logic err);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_write = 1'b0;
    reg_addr  = addr;
    #(CLK_PERIOD / 4);
    data = reg_rdata;
    err  = reg_error;
    queue_check("reg_ready", hsid_x_pkg::word_t'(reg_ready), 32'h1); // Same-cycle answer
    @(negedge clk);
    reg_valid = 1'b0;
  endtask

  task automatic check_read(input string name, input hsid_x_pkg::reg_addr_t addr,
                            input hsid_x_pkg::word_t exp);
    hsid_x_pkg::word_t data;
    logic              err;
    reg_read_task(addr, data, err);
    queue_check(name, data, exp);
    queue_check("reg_error", hsid_x_pkg::word_t'(err), 32'h0); // Known offset
  endtask

  task automatic check_write(input hsid_x_pkg::reg_addr_t addr,
                             input hsid_x_pkg::word_t data, input logic exp_err);
    logic err;
    reg_write_task(addr, data, err);
    queue_check("reg_error", hsid_x_pkg::word_t'(err), hsid_x_pkg::word_t'(exp_err));
  endtask

  task automatic wait_status(input hsid_x_pkg::word_t mask);
    hsid_x_pkg::word_t status;
    logic              err;
    status = '0;
    while ((status & mask) == '0) reg_read_task(hsid_x_pkg::REG_STATUS, status, err);
  endtask

  // Configure, start, poll for done and compare results
  task automatic run_and_check(input hsid_x_pkg::word_t cap_addr,
                               input hsid_x_pkg::word_t lib_addr,
                               input int bands, input int lib_size, input bit busy_write);
    int                min_ref;
    int                max_ref;
    hsid_x_pkg::word_t min_val;
    hsid_x_pkg::word_t max_val;
    check_write(hsid_x_pkg::REG_LIBRARY_SIZE, hsid_x_pkg::word_t'(lib_size), 1'b0);
    check_write(hsid_x_pkg::REG_PIXEL_BANDS, hsid_x_pkg::word_t'(bands), 1'b0);
    check_write(hsid_x_pkg::REG_CAPTURED_ADDR, cap_addr, 1'b0);
    check_write(hsid_x_pkg::REG_LIBRARY_ADDR, lib_addr, 1'b0);
    check_write(hsid_x_pkg::REG_STATUS, START_BIT, 1'b0);
    if (busy_write) begin
      check_write(hsid_x_pkg::REG_LIBRARY_SIZE, hsid_x_pkg::word_t'(lib_size + 1), 1'b1);
    end
    wait_status(DONE_BIT);
    check_read("status", hsid_x_pkg::REG_STATUS, IDLE_BIT | READY_BIT | DONE_BIT);
    if (busy_write) begin
      check_read("library_size", hsid_x_pkg::REG_LIBRARY_SIZE, hsid_x_pkg::word_t'(lib_size));
    end
    ref_min_max(cap_addr, lib_addr, bands, lib_size, min_ref, min_val, max_ref, max_val);
    check_read("mse_min_ref", hsid_x_pkg::REG_MSE_MIN_REF, hsid_x_pkg::word_t'(min_ref));
    check_read("mse_min_value", hsid_x_pkg::REG_MSE_MIN_VALUE, min_val);
    check_read("mse_max_ref", hsid_x_pkg::REG_MSE_MAX_REF, hsid_x_pkg::word_t'(max_ref));
    check_read("mse_max_value", hsid_x_pkg::REG_MSE_MAX_VALUE, max_val);
  endtask

  initial begin
    hsid_x_pkg::word_t cap_addr;
    hsid_x_pkg::word_t lib_addr;
    hsid_x_pkg::word_t data;
    hsid_x_pkg::sample_t cap_s;
    hsid_x_pkg::sample_t far_s;
    int                bands;
    int                lib_size;
    logic              err;
    rst_n     = 1'b0;
    reg_valid = 1'b0;
    reg_write = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    void'($urandom(SEED));
    for (int i = 0; i < MEM_DEPTH; i++) mem[i] = $urandom;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // Reset values, then an unknown offset
    check_read("status", hsid_x_pkg::REG_STATUS, IDLE_BIT);
    for (int off = 4; off <= 32; off += 4) begin
      check_read($sformatf("reg_rdata[0x%02h]", off), hsid_x_pkg::reg_addr_t'(off), '0);
    end
    reg_read_task(8'h24, data, err);
    queue_check("reg_error", hsid_x_pkg::word_t'(err), 32'h1);
    check_write(8'h28, 32'h5a5a, 1'b1);

    // Random configurations
    for (int r = 0; r < 3; r++) begin
      bands    = 1 + int'($urandom % MAX_BANDS);
      lib_size = 1 + int'($urandom % MAX_LIB);
      cap_addr = $urandom % 64;
      lib_addr = 64 + ($urandom % 256);
      run_and_check(cap_addr, lib_addr, bands, lib_size, 1'b0);
    end

    // Entries 1,3 match the pixel and entries 2,4 sit furthest away
    cap_addr = 8;
    lib_addr = 600;
    for (int b = 0; b < 4; b++) begin
      cap_s = mem[8 + b][11:0];
      far_s = (cap_s < 12'd2048) ? 12'hfff : 12'h000;
      mem[600 + 4 + b]  = {mem[600 + 4 + b][31:12], cap_s};  // Upper bits stay random
      mem[600 + 12 + b] = {mem[600 + 12 + b][31:12], cap_s};
      mem[600 + 8 + b]  = {mem[600 + 8 + b][31:12], far_s};
      mem[600 + 16 + b] = {mem[600 + 16 + b][31:12], far_s};
    end
    run_and_check(cap_addr, lib_addr, 4, 5, 1'b0);
    check_read("mse_min_ref", hsid_x_pkg::REG_MSE_MIN_REF, 32'd1);
    check_read("mse_max_ref", hsid_x_pkg::REG_MSE_MAX_REF, 32'd2);

    // Config write during a run is refused
    run_and_check(32'd16, 32'd700, 8, 6, 1'b1);

    // Zero library size, then clear
    check_write(hsid_x_pkg::REG_LIBRARY_SIZE, '0, 1'b0);
    check_write(hsid_x_pkg::REG_STATUS, START_BIT, 1'b0);
    wait_status(ERROR_BIT);
    check_read("status", hsid_x_pkg::REG_STATUS, IDLE_BIT | ERROR_BIT);
    check_write(hsid_x_pkg::REG_STATUS, CLEAR_BIT, 1'b0);
    check_read("status", hsid_x_pkg::REG_STATUS, IDLE_BIT);     // Not ready, size still zero
    check_write(hsid_x_pkg::REG_LIBRARY_SIZE, 32'd3, 1'b0);
    check_read("status", hsid_x_pkg::REG_STATUS, IDLE_BIT | READY_BIT);

    repeat (2) @(negedge clk);
    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0 && check_count > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
hdl/hsid_x_pkg.sv
hdl/hsid_x_ctrl_reg.sv
hdl/hsid_x_sequencer.sv
hdl/hsid_x_mse_accum.sv
hdl/hsid_x_min_max.sv
hdl/hsid_x_top.sv
bench/hsid_x_properties.sv
bench/hsid_x_tb.sv

/* Makefile */
# Verilator build and run for the hyperspectral pixel identification engine

VERILATOR  ?= verilator
TOP        ?= hsid_x_tb
RTL_TOP    ?= hsid_x_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= ALL TESTS PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv bench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status comes from the search for the pass message
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
